//--- design/ad7980_reader.sv
`default_nettype none

module ad7980_reader import adc_pkg::*; #(
    parameter int CONV_CYCLES = 71
) (
    input  logic          clk,
    input  logic          rstn,
    adc_channel_if.reader chan,
    input  logic          sdo,
    output logic          cnv,
    output logic          sclk
);

    // one counter serves both the conversion time and the 2*SAMPLE_BITS read cycles
    localparam int CNT_MAX = (CONV_CYCLES > 2 * SAMPLE_BITS) ? CONV_CYCLES : 2 * SAMPLE_BITS;
    localparam int CNT_W   = $clog2(CNT_MAX) + 1;

    reader_state_t    state;
    logic [CNT_W-1:0] cnt;
    sample_t          shift;
    logic             busy;
    logic             valid;

    assign chan.busy  = busy;
    assign chan.valid = valid;
    assign chan.data  = shift;  // only changes during a read, after the next start

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= READER_IDLE;
            cnt   <= '0;
            busy  <= 1'b0;
            valid <= 1'b0;
            cnv   <= 1'b0;
            sclk  <= 1'b1;
        end else begin
            valid <= 1'b0;
            case (state)
                READER_IDLE: begin
                    // busy stays up through the cycle of the valid pulse
                    busy <= 1'b0;
                    if (chan.start) begin
                        busy  <= 1'b1;
                        cnv   <= 1'b1;
                        cnt   <= '0;
                        state <= READER_CONVERT;
                    end
                end
                READER_CONVERT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CONV_CYCLES - 1)) begin
                        cnv   <= 1'b0;
                        sclk  <= 1'b0;  // first low half of the read
                        cnt   <= '0;
                        state <= READER_READ;
                    end
                end
                READER_READ: begin
                    cnt  <= cnt + 1'b1;
                    sclk <= ~sclk;
                    if (cnt == CNT_W'(2 * SAMPLE_BITS - 1)) begin
                        sclk  <= 1'b1;
                        valid <= 1'b1;
                        state <= READER_IDLE;
                    end
                end
                default: begin
                    state <= READER_IDLE;
                end
            endcase
        end
    end

    // sdo is taken at the end of every low sclk cycle, msb first
    always_ff @(posedge clk) begin
        if (state == READER_READ && !sclk) begin
            shift <= {shift[SAMPLE_BITS-2:0], sdo};
        end
    end

endmodule

`default_nettype wire

//--- design/adc_array_top.sv
`default_nettype none

module adc_array_top import adc_pkg::*; #(
    parameter int NUM_CHANNELS  = 4,
    parameter int CONV_CYCLES   = 71,
    parameter int SAMPLE_PERIOD = 128
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            enable,
    input  logic [NUM_CHANNELS-1:0]         sdo,
    output logic [NUM_CHANNELS-1:0]         cnv,
    output logic [NUM_CHANNELS-1:0]         sclk,
    output sample_t                         sample_data,
    output logic [$clog2(NUM_CHANNELS)-1:0] sample_channel,
    output logic                            sample_valid,
    output logic                            frame_last
);

    // one link per converter with a start that is common to all of them
    adc_channel_if chans [NUM_CHANNELS] ();

    conversion_timer #(
        .SAMPLE_PERIOD (SAMPLE_PERIOD),
        .NUM_CHANNELS  (NUM_CHANNELS)
    ) u_timer (
        .clk    (clk),
        .rstn   (rstn),
        .enable (enable),
        .chans  (chans)
    );

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_reader
        ad7980_reader #(
            .CONV_CYCLES (CONV_CYCLES)
        ) u_reader (
            .clk  (clk),
            .rstn (rstn),
            .chan (chans[g]),
            .sdo  (sdo[g]),
            .cnv  (cnv[g]),
            .sclk (sclk[g])
        );
    end

    sample_collector #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_collector (
        .clk            (clk),
        .rstn           (rstn),
        .chans          (chans),
        .sample_data    (sample_data),
        .sample_channel (sample_channel),
        .sample_valid   (sample_valid),
        .frame_last     (frame_last)
    );

endmodule

`default_nettype wire

//--- design/adc_channel_if.sv
`default_nettype none

interface adc_channel_if import adc_pkg::*; ();

    logic    start;  // common start strobe from the timer
    logic    busy;
    logic    valid;  // one-cycle pulse when data holds a fresh word
    sample_t data;

    modport timer (
        output start,
        input  busy
    );

    modport reader (
        input  start,
        output busy,
        output valid,
        output data
    );

    modport collector (
        input valid,
        input data
    );

endinterface

`default_nettype wire

//--- design/adc_pkg.sv
`default_nettype none

package adc_pkg;

    // the AD7980 fixes the converter word width
    localparam int SAMPLE_BITS = 16;

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    typedef enum logic [1:0] {
        READER_IDLE,
        READER_CONVERT,  // cnv is high while the converter is busy
        READER_READ      // sclk runs while sdo is shifted in
    } reader_state_t;

    typedef enum logic {
        COLLECTOR_GATHER,
        COLLECTOR_DRAIN
    } collector_state_t;

endpackage

`default_nettype wire

//--- design/conversion_timer.sv
`default_nettype none

module conversion_timer import adc_pkg::*; #(
    parameter int SAMPLE_PERIOD = 128,
    parameter int NUM_CHANNELS  = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               enable,
    adc_channel_if.timer       chans [NUM_CHANNELS]
);

    localparam int CNT_W = $clog2(SAMPLE_PERIOD);

    logic [CNT_W-1:0]        cnt;
    logic                    start;
    logic [NUM_CHANNELS-1:0] busy_vec;
    logic                    any_busy;

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        assign chans[g].start = start;
        assign busy_vec[g]    = chans[g].busy;
    end

    assign any_busy = |busy_vec;

    // cnt counts down to zero, a start is only issued at zero with every reader idle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cnt   <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (!enable) begin
                cnt <= '0;  // next enable starts a conversion right away
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end else if (!any_busy) begin
                start <= 1'b1;
                cnt   <= CNT_W'(SAMPLE_PERIOD - 1);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sample_collector.sv
`default_nettype none

module sample_collector import adc_pkg::*; #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                            clk,
    input  logic                            rstn,
    adc_channel_if.collector                chans [NUM_CHANNELS],
    output sample_t                         sample_data,
    output logic [$clog2(NUM_CHANNELS)-1:0] sample_channel,
    output logic                            sample_valid,
    output logic                            frame_last
);

    localparam int IDX_W = $clog2(NUM_CHANNELS);

    collector_state_t        state;
    logic [NUM_CHANNELS-1:0] arrived;
    logic [NUM_CHANNELS-1:0] arrived_next;
    logic [NUM_CHANNELS-1:0] valid_vec;
    sample_t                 data_vec [NUM_CHANNELS];
    sample_t                 words [NUM_CHANNELS];
    logic [IDX_W-1:0]        idx;

    for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
        assign valid_vec[g] = chans[g].valid;
        assign data_vec[g]  = chans[g].data;

        always_ff @(posedge clk) begin
            if (valid_vec[g]) begin
                words[g] <= data_vec[g];
            end
        end
    end

    assign arrived_next = arrived | valid_vec;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= COLLECTOR_GATHER;
            arrived <= '0;
            idx     <= '0;
        end else begin
            case (state)
                COLLECTOR_GATHER: begin
                    arrived <= arrived_next;
                    idx     <= '0;
                    if (&arrived_next) begin
                        state <= COLLECTOR_DRAIN;  // channel 0 goes out next cycle
                    end
                end
                COLLECTOR_DRAIN: begin
                    idx <= idx + 1'b1;
                    if (idx == IDX_W'(NUM_CHANNELS - 1)) begin
                        idx     <= '0;
                        arrived <= '0;
                        state   <= COLLECTOR_GATHER;
                    end
                end
                default: begin
                    state <= COLLECTOR_GATHER;
                end
            endcase
        end
    end

    // one word per cycle in channel order with no back-pressure
    assign sample_valid   = (state == COLLECTOR_DRAIN);
    assign sample_channel = idx;
    assign sample_data    = words[idx];
    assign frame_last     = sample_valid && (idx == IDX_W'(NUM_CHANNELS - 1));

endmodule

`default_nettype wire

//--- list.f
design/adc_pkg.sv
design/adc_channel_if.sv
design/conversion_timer.sv
design/ad7980_reader.sv
design/sample_collector.sv
design/adc_array_top.sv
tb/ad7980_model.sv
tb/adc_array_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module adc_array_tb -o adc_array_sim

out=$(./obj_dir/adc_array_sim)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- tb/ad7980_model.sv
`default_nettype none

module ad7980_model import adc_pkg::*; (
    input  logic    cnv,
    input  logic    sclk,
    input  sample_t preset,  // word to convert at the next cnv rising edge
    output sample_t word,    // word converted at the last cnv rising edge
    output logic    sdo
);

    sample_t held    = '0;
    logic    bit_out = 1'b0;
    int      nfall   = 0;

    assign word = held;
    assign sdo  = bit_out;

    // sclk idles high, so a trigger with sclk high can only be a cnv rising edge
    always @(posedge cnv or negedge sclk) begin
        if (sclk) begin
            held  = preset;
            nfall = 0;
        end else begin
            // the first falling sclk puts out the msb, each later one the next bit
            if (nfall < SAMPLE_BITS) begin
                bit_out = held[SAMPLE_BITS-1-nfall];
            end
            nfall = nfall + 1;
        end
    end

endmodule

`default_nettype wire

//--- tb/adc_array_tb.sv
`default_nettype none

module adc_array_tb import adc_pkg::*; ();

    localparam int NUM_CH        = 4;
    localparam int CONV          = 10;
    localparam int PERIOD        = 80;
    localparam int LATENCY       = CONV + 2 * SAMPLE_BITS + 1;
    localparam int TIMEOUT_LIMIT = 12 * PERIOD + 400;

    logic              clk = 1'b0;
    logic              rstn;
    logic              enable;
    logic [NUM_CH-1:0] sdo = '0;
    logic [NUM_CH-1:0] cnv;
    logic [NUM_CH-1:0] sclk;
    sample_t           sample_data;
    logic [1:0]        sample_channel;
    logic              sample_valid;
    logic              frame_last;

    logic [NUM_CH-1:0] model_sdo;
    sample_t           model_word [NUM_CH];
    sample_t           preset [NUM_CH];
    logic [NUM_CH-1:0] cnv_q = '0;
    logic [31:0]       lfsr = 32'hf108d8e5;
    logic              primed = 1'b0;

    int         cnv_len [NUM_CH];
    int         sclk_lows [NUM_CH];
    int         lat_cnt = 0;
    int         gap = 0;
    logic       chained = 1'b0;
    logic       fresh = 1'b0;
    logic       rst_q = 1'b0;
    logic [1:0] exp_chan = '0;
    int         en_low_cnt = 0;
    int         frames = 0;
    int         cycles = 0;

    int data_errors = 0;
    int order_errors = 0;
    int timing_errors = 0;
    int control_errors = 0;

    always #50 clk = ~clk;

    adc_array_top #(
        .NUM_CHANNELS  (NUM_CH),
        .CONV_CYCLES   (CONV),
        .SAMPLE_PERIOD (PERIOD)
    ) dut (
        .clk            (clk),
        .rstn           (rstn),
        .enable         (enable),
        .sdo            (sdo),
        .cnv            (cnv),
        .sclk           (sclk),
        .sample_data    (sample_data),
        .sample_channel (sample_channel),
        .sample_valid   (sample_valid),
        .frame_last     (frame_last)
    );

    for (genvar g = 0; g < NUM_CH; g++) begin : g_model
        ad7980_model u_model (
            .cnv    (cnv[g]),
            .sclk   (sclk[g]),
            .preset (preset[g]),
            .word   (model_word[g]),
            .sdo    (model_sdo[g])
        );
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1
    endfunction

    task automatic draw_word(output sample_t w);
        w = '0;
        for (int i = 0; i < SAMPLE_BITS; i++) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[SAMPLE_BITS-2:0], lfsr[0]};
        end
    endtask

    // new preset after each cnv rise, and sdo passed on at the falling clock edge
    always @(negedge clk) begin
        sample_t w;
        for (int g = 0; g < NUM_CH; g++) begin
            if (!primed || (cnv[g] && !cnv_q[g])) begin
                draw_word(w);
                preset[g] = w;
            end
        end
        primed = 1'b1;
        cnv_q  = cnv;
        sdo    = model_sdo;
    end

    // counters that the assertions below look at
    always @(posedge clk) begin
        rst_q <= !rstn;
        if (sample_valid && frame_last) frames <= frames + 1;
        en_low_cnt <= enable ? 0 : en_low_cnt + 1;
        if (!rstn) begin
            lat_cnt  <= 0;
            gap      <= 0;
            chained  <= 1'b0;
            fresh    <= 1'b0;
            exp_chan <= '0;
            for (int g = 0; g < NUM_CH; g++) begin
                cnv_len[g]   <= 0;
                sclk_lows[g] <= 0;
            end
        end else begin
            if (sample_valid) exp_chan <= exp_chan + 2'd1;
            if (sclk_lows[0] == SAMPLE_BITS) fresh <= 1'b1;
            if (cnv[0] && cnv_len[0] == 0) begin
                lat_cnt <= 1;
                gap     <= 1;
                chained <= 1'b1;
            end else begin
                if (lat_cnt != 0) lat_cnt <= lat_cnt + 1;
                gap <= gap + 1;
                if (!enable) chained <= 1'b0;
            end
            for (int g = 0; g < NUM_CH; g++) begin
                cnv_len[g] <= cnv[g] ? cnv_len[g] + 1 : 0;
                if (cnv[g] && cnv_len[g] == 0) sclk_lows[g] <= 0;
                else if (!sclk[g]) sclk_lows[g] <= sclk_lows[g] + 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        sample_valid |-> sample_data == model_word[sample_channel])
    else begin
        data_errors++;
        $display("mismatch at %0t: channel %0d gave %h, model loaded %h", $time,
                 sample_channel, sample_data, model_word[sample_channel]);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (sample_valid || exp_chan != 0) |-> (sample_valid && sample_channel == exp_chan))
    else begin
        order_errors++;
        $display("mismatch at %0t: channel %0d with valid %b, expected channel %0d", $time,
                 sample_channel, sample_valid, exp_chan);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        frame_last == (sample_valid && exp_chan == 2'd3))
    else begin
        order_errors++;
        $display("mismatch at %0t: frame_last %b on channel %0d", $time, frame_last,
                 sample_channel);
    end

    for (genvar g = 0; g < NUM_CH; g++) begin : g_link_check
        assert property (@(posedge clk) disable iff (!rstn)
            (!cnv[g] && cnv_len[g] != 0) |-> cnv_len[g] == CONV)
        else begin
            timing_errors++;
            $display("mismatch at %0t: cnv %0d was high for %0d cycles", $time, g, cnv_len[g]);
        end

        assert property (@(posedge clk) disable iff (!rstn)
            (sample_valid && frame_last) |-> sclk_lows[g] == SAMPLE_BITS)
        else begin
            timing_errors++;
            $display("mismatch at %0t: sclk %0d had %0d low cycles", $time, g, sclk_lows[g]);
        end

        assert property (@(posedge clk) disable iff (!rstn)
            (!cnv[g] || sclk[g]) && sclk_lows[g] <= SAMPLE_BITS)
        else begin
            timing_errors++;
            $display("mismatch at %0t: sclk %0d ran outside its read phase", $time, g);
        end
    end

    // 43 edges from the first cnv high cycle to channel 0 on the output
    assert property (@(posedge clk) disable iff (!rstn)
        (sample_valid && sample_channel == 2'd0) |-> lat_cnt == LATENCY)
    else begin
        timing_errors++;
        $display("mismatch at %0t: first word %0d cycles after cnv rise", $time, lat_cnt);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (cnv[0] && cnv_len[0] == 0 && chained) |-> gap == PERIOD)
    else begin
        timing_errors++;
        $display("mismatch at %0t: cnv rises %0d cycles apart", $time, gap);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (en_low_cnt < 3 || !(cnv[0] && cnv_len[0] == 0))
        && (en_low_cnt < 60 || !sample_valid))
    else begin
        control_errors++;
        $display("mismatch at %0t: activity while enable is low", $time);
    end

    assert property (@(posedge clk) disable iff (!rstn)
        sample_valid |-> fresh)
    else begin
        control_errors++;
        $display("mismatch at %0t: sample_valid before a full conversion", $time);
    end

    assert property (@(posedge clk)
        rst_q |-> (cnv == '0 && sclk == '1 && !sample_valid && !frame_last))
    else begin
        control_errors++;
        $display("mismatch at %0t: outputs not at their reset values", $time);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic wait_frames(input int n);
        int target;
        target = frames + n;
        while (frames < target) @(negedge clk);
    endtask

    initial begin
        int total;
        rstn   = 1'b0;
        enable = 1'b0;
        repeat (5) @(negedge clk);
        rstn   = 1'b1;
        enable = 1'b1;
        wait_frames(8);

        enable = 1'b0;  // long enough to let the last frame drain
        repeat (120) @(negedge clk);
        enable = 1'b1;
        wait_frames(2);

        // reset in the middle of a conversion
        @(posedge cnv[0]);
        repeat (5) @(negedge clk);
        rstn = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        wait_frames(2);

        total = data_errors + order_errors + timing_errors + control_errors;
        $display("errors: data %0d order %0d timing %0d control %0d", data_errors,
                 order_errors, timing_errors, control_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
